/* elevator_pkg.sv */
// Shared floor and state types, LED codes and seven-segment decode functions
package elevator_pkg;

    localparam int NUM_FLOORS = 8;                 // Floors 0 to 7

    typedef logic [2:0] floor_t;                   // Floor number
    typedef logic [NUM_FLOORS-1:0] floor_vec_t;    // One flag per floor, indexed by floor

    // Car FSM states
    typedef enum logic [2:0] {
        RESET_STATE,                               // First cycle out of reset
        IDLE,                                      // Waiting for a call
        MOVING_UP,                                 // Travelling up one floor per step
        MOVING_DOWN,                               // Travelling down one floor per step
        DOOR_OPEN,                                 // Door held open at a stop
        DOOR_CLOSE,                                // Door closing before idle
        EMERGENCY                                  // Frozen until emergency drops
    } car_state_t;

    typedef logic [2:0] led_t;                     // Packed as {r, g, b}

    localparam led_t LED_IDLE       = 3'b010;      // Green
    localparam led_t LED_UP         = 3'b001;      // Blue
    localparam led_t LED_DOWN       = 3'b110;      // Red and green
    localparam led_t LED_DOOR_OPEN  = 3'b011;      // Green and blue
    localparam led_t LED_DOOR_CLOSE = 3'b101;      // Red and blue
    localparam led_t LED_EMERGENCY  = 3'b100;      // Red

    // Active-low cathode pattern, segment a in bit 6 down to g in bit 0
    function automatic logic [6:0] seg_digit(input floor_t floor);
        logic [6:0] pattern;
        case (floor)
            3'd0:    pattern = 7'b0000001;
            3'd1:    pattern = 7'b1001111;
            3'd2:    pattern = 7'b0010010;
            3'd3:    pattern = 7'b0000110;
            3'd4:    pattern = 7'b1001100;
            3'd5:    pattern = 7'b0100100;
            3'd6:    pattern = 7'b0100000;
            3'd7:    pattern = 7'b0001111;
            default: pattern = 7'b1111111;         // Blank
        endcase
        return pattern;
    endfunction

    // Active-low one-hot anode, digit n lights for floor n
    function automatic logic [NUM_FLOORS-1:0] anode_select(input floor_t floor);
        logic [NUM_FLOORS-1:0] onehot;
        onehot = '0;
        onehot[floor] = 1'b1;                      // Select this floor's digit
        return ~onehot;                            // Anodes are active low
    endfunction

endpackage

/* call_register.sv */
`timescale 1ns/10ps
// Hall call register holding the up and down call vectors with set and clear logic
module call_register (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     valid_in,      // One-cycle request strobe
    input  logic                     direction,     // High for up call, low for down call
    input  elevator_pkg::floor_t     req_floor,     // Floor of the new call
    input  elevator_pkg::floor_t     current_floor, // Floor where clears apply
    input  logic                     clear_up,      // Clear up call at current floor
    input  logic                     clear_down,    // Clear down call at current floor
    output elevator_pkg::floor_vec_t up_calls,
    output elevator_pkg::floor_vec_t down_calls
);
    import elevator_pkg::*;

    floor_vec_t req_onehot;                         // Decoded request floor
    floor_vec_t cur_onehot;                         // Decoded car floor
    floor_vec_t up_set;
    floor_vec_t down_set;
    floor_vec_t up_clr;
    floor_vec_t down_clr;

    always_comb begin
        req_onehot = '0;
        req_onehot[req_floor] = 1'b1;
        cur_onehot = '0;
        cur_onehot[current_floor] = 1'b1;
    end

    // Set masks from the request strobe
    assign up_set   = (valid_in && direction)  ? req_onehot : '0;
    assign down_set = (valid_in && !direction) ? req_onehot : '0;

    // Clear masks from the arrival pulses
    assign up_clr   = clear_up   ? cur_onehot : '0;
    assign down_clr = clear_down ? cur_onehot : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            up_calls   <= '0;                       // No calls after reset
            down_calls <= '0;
        end else begin
            // Set after clear so a new request beats a clear on the same bit
            up_calls   <= (up_calls & ~up_clr) | up_set;
            down_calls <= (down_calls & ~down_clr) | down_set;
        end
    end

endmodule

/* target_select.sv */
`timescale 1ns/10ps
// Target selection with above and below priority searches and registered target floor
module target_select (
    input  logic                     clk,
    input  logic                     reset,
    input  elevator_pkg::floor_vec_t up_calls,
    input  elevator_pkg::floor_vec_t down_calls,
    input  elevator_pkg::floor_t     current_floor,
    input  logic                     heading_up,    // Last travel direction
    output elevator_pkg::floor_t     target_floor,  // Next floor to serve
    output logic                     call_pending   // Any call outstanding
);
    import elevator_pkg::*;

    floor_vec_t all_calls;                          // Up or down call per floor
    logic       here_any;                           // Call at the car's floor
    logic       above_any;                          // Call anywhere above the car
    logic       below_any;                          // Call anywhere below the car
    floor_t     low_above;                          // Nearest call above
    floor_t     high_below;                         // Nearest call below
    floor_t     target_next;

    assign all_calls = up_calls | down_calls;
    assign here_any  = all_calls[current_floor];

    // Lowest call above the car, scanned downward so the last hit wins
    always_comb begin
        above_any = 1'b0;
        low_above = current_floor;
        for (int i = NUM_FLOORS - 1; i >= 0; i--) begin
            if (all_calls[i] && (floor_t'(i) > current_floor)) begin
                above_any = 1'b1;
                low_above = floor_t'(i);
            end
        end
    end

    // Highest call below the car, scanned upward so the last hit wins
    always_comb begin
        below_any  = 1'b0;
        high_below = current_floor;
        for (int i = 0; i < NUM_FLOORS; i++) begin
            if (all_calls[i] && (floor_t'(i) < current_floor)) begin
                below_any  = 1'b1;
                high_below = floor_t'(i);
            end
        end
    end

    // Serve here first, keep the travel direction, then turn around
    always_comb begin
        if (here_any)
            target_next = current_floor;
        else if (heading_up && above_any)
            target_next = low_above;                // Continue upward
        else if (below_any)
            target_next = high_below;               // Downward or turning down
        else if (above_any)
            target_next = low_above;                // Turning up
        else
            target_next = current_floor;            // Nothing to serve
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            target_floor <= '0;
            call_pending <= 1'b0;
        end else begin
            target_floor <= target_next;
            call_pending <= |all_calls;             // Same cycle as the target
        end
    end

endmodule

/* car_controller.sv */
`timescale 1ns/10ps
// Car FSM with floor register, direction memory, shared tick timer and call clear pulses
module car_controller #(
    parameter int FLOOR_TICKS      = 4,             // Cycles per floor step
    parameter int DOOR_OPEN_TICKS  = 3,             // Cycles with door open
    parameter int DOOR_CLOSE_TICKS = 5              // Cycles for door closing
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     emergency,     // Level, freezes the car
    input  elevator_pkg::floor_vec_t up_calls,
    input  elevator_pkg::floor_vec_t down_calls,
    input  elevator_pkg::floor_t     target_floor,
    input  logic                     call_pending,
    output elevator_pkg::floor_t     current_floor,
    output logic                     heading_up,    // 1 after an upward departure
    output elevator_pkg::car_state_t car_state,
    output logic                     clear_up,      // Arrival pulse for up call
    output logic                     clear_down     // Arrival pulse for down call
);
    import elevator_pkg::*;

    localparam int DOOR_MAX = (DOOR_OPEN_TICKS > DOOR_CLOSE_TICKS) ?
                              DOOR_OPEN_TICKS : DOOR_CLOSE_TICKS;
    localparam int TICK_MAX = (FLOOR_TICKS > DOOR_MAX) ? FLOOR_TICKS : DOOR_MAX;
    localparam int TICK_W   = (TICK_MAX > 1) ? $clog2(TICK_MAX) : 1;

    car_state_t        state_next;
    floor_t            floor_next;
    floor_t            floor_up;                    // Floor reached by an up step
    floor_t            floor_dn;                    // Floor reached by a down step
    logic              heading_next;
    logic              clear_up_next;
    logic              clear_down_next;
    logic [TICK_W-1:0] tick_cnt;                    // Cycles spent in the current interval
    logic [TICK_W-1:0] tick_last;                   // Final count of the interval
    logic              tick_done;

    assign floor_up = current_floor + 3'd1;
    assign floor_dn = current_floor - 3'd1;

    // Interval length per state
    always_comb begin
        case (car_state)
            MOVING_UP, MOVING_DOWN: tick_last = TICK_W'(FLOOR_TICKS - 1);
            DOOR_OPEN:              tick_last = TICK_W'(DOOR_OPEN_TICKS - 1);
            DOOR_CLOSE:             tick_last = TICK_W'(DOOR_CLOSE_TICKS - 1);
            default:                tick_last = '0;  // Untimed states
        endcase
    end

    assign tick_done = (tick_cnt == tick_last);

    always_comb begin
        state_next      = car_state;
        floor_next      = current_floor;
        heading_next    = heading_up;
        clear_up_next   = 1'b0;
        clear_down_next = 1'b0;
        if (emergency) begin
            state_next = EMERGENCY;                 // Overrides every state, floor holds
        end else begin
            case (car_state)
                RESET_STATE: state_next = IDLE;
                IDLE: begin
                    if (call_pending) begin
                        if (target_floor == current_floor) begin
                            state_next      = DOOR_OPEN;   // Call at this floor
                            clear_up_next   = 1'b1;
                            clear_down_next = 1'b1;
                        end else if (target_floor > current_floor) begin
                            state_next   = MOVING_UP;
                            heading_next = 1'b1;
                        end else begin
                            state_next   = MOVING_DOWN;
                            heading_next = 1'b0;
                        end
                    end
                end
                MOVING_UP: begin
                    if (tick_done) begin
                        floor_next = floor_up;             // One floor per step
                        // Stopping at or beyond the target also stops at the top floor
                        if (floor_up >= target_floor || up_calls[floor_up]) begin
                            state_next      = DOOR_OPEN;
                            clear_up_next   = 1'b1;
                            clear_down_next = (floor_up == target_floor);
                        end
                    end
                end
                MOVING_DOWN: begin
                    if (tick_done) begin
                        floor_next = floor_dn;
                        // Stopping at or below the target also stops at floor 0
                        if (floor_dn <= target_floor || down_calls[floor_dn]) begin
                            state_next      = DOOR_OPEN;
                            clear_down_next = 1'b1;
                            clear_up_next   = (floor_dn == target_floor);
                        end
                    end
                end
                DOOR_OPEN:  if (tick_done) state_next = DOOR_CLOSE;
                DOOR_CLOSE: if (tick_done) state_next = IDLE;
                EMERGENCY:  state_next = IDLE;      // Emergency released
                default:    state_next = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            car_state     <= RESET_STATE;
            current_floor <= '0;                    // Car parks at floor 0
            heading_up    <= 1'b0;
            clear_up      <= 1'b0;
            clear_down    <= 1'b0;
            tick_cnt      <= '0;
        end else begin
            car_state     <= state_next;
            current_floor <= floor_next;
            heading_up    <= heading_next;
            clear_up      <= clear_up_next;         // Lands with the new floor
            clear_down    <= clear_down_next;
            // Restart on a state change or at the end of an interval
            if (state_next != car_state || tick_done)
                tick_cnt <= '0;
            else
                tick_cnt <= tick_cnt + TICK_W'(1);
        end
    end

endmodule

/* floor_display.sv */
`timescale 1ns/10ps
// Registered display with anode select, floor digit and status LEDs
module floor_display (
    input  logic                     clk,
    input  logic                     reset,
    input  elevator_pkg::floor_t     current_floor,
    input  elevator_pkg::car_state_t car_state,
    output logic [7:0]               anode,         // Active-low digit select
    output logic [6:0]               cathode,       // Active-low segments
    output logic                     r,
    output logic                     g,
    output logic                     b
);
    import elevator_pkg::*;

    led_t led_code;                                 // {r, g, b} for the state

    always_comb begin
        case (car_state)
            IDLE:        led_code = LED_IDLE;
            MOVING_UP:   led_code = LED_UP;
            MOVING_DOWN: led_code = LED_DOWN;
            DOOR_OPEN:   led_code = LED_DOOR_OPEN;
            DOOR_CLOSE:  led_code = LED_DOOR_CLOSE;
            EMERGENCY:   led_code = LED_EMERGENCY;
            default:     led_code = '0;             // Dark in RESET_STATE
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            anode     <= anode_select('0);          // Show floor 0
            cathode   <= seg_digit('0);
            {r, g, b} <= '0;                        // LEDs off
        end else begin
            anode     <= anode_select(current_floor);
            cathode   <= seg_digit(current_floor);
            {r, g, b} <= led_code;
        end
    end

endmodule

/* elevator.sv */
`timescale 1ns/10ps
// Elevator top level connecting call register, target select, car controller and display
module elevator #(
    parameter int FLOOR_TICKS      = 4,             // Cycles per floor step
    parameter int DOOR_OPEN_TICKS  = 3,             // Cycles with door open
    parameter int DOOR_CLOSE_TICKS = 5              // Cycles for door closing
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid_in,          // Request strobe
    input  logic                 direction,         // 1 up, 0 down
    input  elevator_pkg::floor_t req_floor,
    input  logic                 emergency,
    output logic [6:0]           cathode,
    output logic [7:0]           anode,
    output logic                 r,
    output logic                 g,
    output logic                 b
);
    import elevator_pkg::*;

    floor_vec_t up_calls;
    floor_vec_t down_calls;
    floor_t     target_floor;
    logic       call_pending;
    floor_t     current_floor;
    logic       heading_up;
    car_state_t car_state;
    logic       clear_up;
    logic       clear_down;

    call_register u_call_register (
        .clk           (clk),
        .reset         (reset),
        .valid_in      (valid_in),
        .direction     (direction),
        .req_floor     (req_floor),
        .current_floor (current_floor),
        .clear_up      (clear_up),
        .clear_down    (clear_down),
        .up_calls      (up_calls),
        .down_calls    (down_calls)
    );

    target_select u_target_select (
        .clk           (clk),
        .reset         (reset),
        .up_calls      (up_calls),
        .down_calls    (down_calls),
        .current_floor (current_floor),
        .heading_up    (heading_up),
        .target_floor  (target_floor),
        .call_pending  (call_pending)
    );

    car_controller #(
        .FLOOR_TICKS      (FLOOR_TICKS),
        .DOOR_OPEN_TICKS  (DOOR_OPEN_TICKS),
        .DOOR_CLOSE_TICKS (DOOR_CLOSE_TICKS)
    ) u_car_controller (
        .clk           (clk),
        .reset         (reset),
        .emergency     (emergency),
        .up_calls      (up_calls),
        .down_calls    (down_calls),
        .target_floor  (target_floor),
        .call_pending  (call_pending),
        .current_floor (current_floor),
        .heading_up    (heading_up),
        .car_state     (car_state),
        .clear_up      (clear_up),
        .clear_down    (clear_down)
    );

    floor_display u_floor_display (
        .clk           (clk),
        .reset         (reset),
        .current_floor (current_floor),
        .car_state     (car_state),
        .anode         (anode),
        .cathode       (cathode),
        .r             (r),
        .g             (g),
        .b             (b)
    );

endmodule

/* elevator_assertions.sv */
`timescale 1ns/10ps
// Concurrent checks on clear pulses, floor steps and floor hold, bound to car_controller
module elevator_assertions (
    input logic                     clk,
    input logic                     reset,
    input elevator_pkg::floor_t     current_floor,
    input elevator_pkg::car_state_t car_state,
    input logic                     clear_up,
    input logic                     clear_down
);
    import elevator_pkg::*;

    int clear_fails = 0;                            // Failure counts per property
    int step_fails  = 0;
    int hold_fails  = 0;

    // Clears land with the first cycle of DOOR_OPEN
    a_clear_on_arrival: assert property (@(posedge clk) disable iff (reset)
        (clear_up || clear_down) |->
            (car_state == DOOR_OPEN && $past(car_state) != DOOR_OPEN))
    else begin
        $error("call clear pulsed outside an arrival");
        clear_fails++;
    end

    // Compared as integers so a wrap between floor 7 and floor 0 counts as a jump
    a_floor_step: assert property (@(posedge clk) disable iff (reset)
        (current_floor != $past(current_floor)) |->
            (int'(current_floor) == int'($past(current_floor)) + 1 ||
             int'(current_floor) == int'($past(current_floor)) - 1))
    else begin
        $error("current floor jumped by more than one");
        step_fails++;
    end

    // Floor only moves out of a travel state, never in emergency or at the door
    a_floor_hold: assert property (@(posedge clk) disable iff (reset)
        (current_floor != $past(current_floor)) |->
            ($past(car_state) == MOVING_UP || $past(car_state) == MOVING_DOWN))
    else begin
        $error("current floor changed outside a moving state");
        hold_fails++;
    end

endmodule

bind car_controller elevator_assertions u_elevator_assertions (
    .clk           (clk),
    .reset         (reset),
    .current_floor (current_floor),
    .car_state     (car_state),
    .clear_up      (clear_up),
    .clear_down    (clear_down)
);

/* tb_elevator.sv */
`timescale 1ns/10ps
// Elevator testbench with clock, reset, vector file reader, display decode, monitor and checks
module tb_elevator;
    import elevator_pkg::*;

    localparam int FLOOR_TICKS      = 4;
    localparam int DOOR_OPEN_TICKS  = 3;
    localparam int DOOR_CLOSE_TICKS = 5;
    localparam int WAIT_LIMIT       = 400;          // Cycles allowed for any single wait
    localparam int HOLD_CYCLES      = 6;            // Cycles the floor must hold in emergency

    logic       clk;
    logic       reset;
    logic       valid_in;
    logic       direction;
    floor_t     req_floor;
    logic       emergency;
    logic [6:0] cathode;
    logic [7:0] anode;
    logic       r;
    logic       g;
    logic       b;

    int    errors;                                  // Wrong values and bad vector lines
    int    timeouts;                                // Waits that ran out
    int    assert_fails;                            // Failures seen by the bound checker
    int    shown_floor;                             // Floor decoded from the anodes
    int    last_floor;
    led_t  last_led;                                // LED code at the latest sample
    int    door_log[$];                             // Floors of door openings, oldest first
    string words[$];                                // Tokens of the current vector line

    elevator #(
        .FLOOR_TICKS      (FLOOR_TICKS),
        .DOOR_OPEN_TICKS  (DOOR_OPEN_TICKS),
        .DOOR_CLOSE_TICKS (DOOR_CLOSE_TICKS)
    ) u_elevator (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (valid_in),
        .direction (direction),
        .req_floor (req_floor),
        .emergency (emergency),
        .cathode   (cathode),
        .anode     (anode),
        .r         (r),
        .g         (g),
        .b         (b)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                     // 100 ns period
    end

    task automatic check_value(input int actual, input int expected, input string msg);
        if (actual != expected) begin
            $display("Mismatch at %0d ns: %s (got %0d, expected %0d)",
                     $time, msg, actual, expected);
            errors++;
        end
    endtask

    // Floor whose anode pattern matches, -1 when none does
    function automatic int decode_floor(input logic [7:0] sel);
        int found;
        found = -1;
        for (int f = 0; f < NUM_FLOORS; f++) begin
            if (sel == anode_select(floor_t'(f)))
                found = f;
        end
        return found;
    endfunction

    // Display checks and door-open log, run at every falling edge
    task automatic observe_display();
        led_t led;
        led         = {r, g, b};
        shown_floor = decode_floor(anode);
        check_value(int'(shown_floor >= 0), 1, "anode is a one-hot floor select");
        if (shown_floor >= 0) begin
            check_value(int'(cathode), int'(seg_digit(floor_t'(shown_floor))),
                        "cathode digit for the shown floor");
            if (shown_floor != last_floor) begin
                check_value(int'(shown_floor == last_floor + 1 ||
                                 shown_floor == last_floor - 1), 1, "floor moved by one step");
                if (shown_floor > last_floor)     // Arrival shows door-open with the new floor
                    check_value(int'(led == LED_UP || led == LED_DOOR_OPEN), 1,
                                "up code while rising");
                else
                    check_value(int'(led == LED_DOWN || led == LED_DOOR_OPEN), 1,
                                "down code while falling");
            end
            last_floor = shown_floor;
        end
        if (led == LED_DOOR_OPEN && last_led != LED_DOOR_OPEN) begin
            door_log.push_back(shown_floor);      // Rising entry into door-open
            $display("Door opens at floor %0d, time %0d ns", shown_floor, $time);
        end
        last_led = led;
    endtask

    task automatic next_cycle();
        @(negedge clk);                             // Outputs settled, inputs change here
        observe_display();
    endtask

    task automatic pulse_request(input int floor, input int up);
        req_floor = floor_t'(floor);
        direction = (up != 0);
        valid_in  = 1'b1;                           // One-cycle strobe
        next_cycle();
        valid_in  = 1'b0;
    endtask

    task automatic wait_stop(input int floor);
        int n;
        n = 0;
        while (door_log.size() == 0 && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (door_log.size() == 0) begin
            $display("Timeout at %0d ns: the door never opened for the stop at floor %0d",
                     $time, floor);
            timeouts++;
        end else begin
            check_value(door_log.pop_front(), floor, "floor of the next door opening");
        end
    endtask

    task automatic wait_idle(input int floor);
        int n;
        n = 0;
        while (!(last_led == LED_IDLE && shown_floor == floor) && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!(last_led == LED_IDLE && shown_floor == floor)) begin
            $display("Timeout at %0d ns: the car never went idle at floor %0d", $time, floor);
            timeouts++;
        end
    endtask

    // Raise is applied once the car travels, then red and a frozen floor are expected
    task automatic set_emergency(input logic on);
        int n;
        int held;
        n = 0;
        if (on) begin
            while (!(last_led == LED_UP || last_led == LED_DOWN) && n < WAIT_LIMIT) begin
                next_cycle();
                n++;
            end
            if (!(last_led == LED_UP || last_led == LED_DOWN)) begin
                $display("Timeout at %0d ns: the car never started to travel before the stop",
                         $time);
                timeouts++;
            end
            emergency = 1'b1;
            n = 0;
            while (last_led != LED_EMERGENCY && n < WAIT_LIMIT) begin
                next_cycle();
                n++;
            end
            if (last_led != LED_EMERGENCY) begin
                $display("Timeout at %0d ns: the red emergency code never appeared", $time);
                timeouts++;
            end
            held = shown_floor;
            repeat (HOLD_CYCLES) begin
                next_cycle();
                check_value(int'(last_led), int'(LED_EMERGENCY), "red code during emergency");
                check_value(shown_floor, held, "floor held during emergency");
            end
        end else begin
            emergency = 1'b0;
            while (last_led == LED_EMERGENCY && n < WAIT_LIMIT) begin
                next_cycle();
                n++;
            end
            if (last_led == LED_EMERGENCY) begin
                $display("Timeout at %0d ns: the car stayed in emergency after release", $time);
                timeouts++;
            end
        end
    endtask

    // Break a vector line into words, dropping anything after a hash
    task automatic split_words(input string line);
        int  start;
        bit  comment;
        byte c;
        start   = -1;
        comment = 1'b0;
        words.delete();
        for (int i = 0; i <= line.len(); i++) begin
            c = (i < line.len()) ? line[i] : 8'h20;  // End of line acts as a space
            if (c == "#")
                comment = 1'b1;
            if (comment || c == " " || c == "\t" || c == "\n" || c == "\r") begin
                if (start >= 0)
                    words.push_back(line.substr(start, i - 1));
                start = -1;
            end else if (start < 0) begin
                start = i;
            end
        end
    endtask

    task automatic run_command();
        if (words[0] == "req" && words.size() >= 3) begin
            pulse_request(words[1].atoi(), words[2].atoi());
        end else if (words[0] == "emg" && words.size() >= 2) begin
            set_emergency(words[1] == "on");
        end else if (words[0] == "stops") begin
            for (int k = 1; k < words.size(); k++)
                wait_stop(words[k].atoi());   // Expected door openings in order
        end else if (words[0] == "idle" && words.size() >= 2) begin
            wait_idle(words[1].atoi());
        end else begin
            $display("Unreadable vector line starting with %s", words[0]);
            errors++;
        end
    endtask

    task automatic run_vectors();
        int    fd;
        string line;
        fd = $fopen("elevator_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open elevator_vectors.txt for reading");
            errors++;
        end else begin
            while (!$feof(fd) && timeouts == 0) begin   // Stop after the first timeout
                line = "";
                if ($fgets(line, fd) != 0) begin
                    split_words(line);
                    if (words.size() > 0)
                        run_command();
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        errors      = 0;
        timeouts    = 0;
        shown_floor = 0;
        last_floor  = 0;
        last_led    = '0;
        reset       = 1'b1;
        valid_in    = 1'b0;
        direction   = 1'b0;
        req_floor   = '0;
        emergency   = 1'b0;
        repeat (3) @(negedge clk);                  // Three reset cycles
        reset = 1'b0;
        // Display leaves reset at floor 0 with the LEDs dark
        check_value(int'(anode), int'(anode_select('0)), "anode after reset");
        check_value(int'(cathode), int'(seg_digit('0)), "cathode after reset");
        check_value(int'({r, g, b}), 0, "LEDs after reset");
        run_vectors();
        check_value(door_log.size(), 0, "door openings left unchecked in the log");
        assert_fails = u_elevator.u_car_controller.u_elevator_assertions.clear_fails
                     + u_elevator.u_car_controller.u_elevator_assertions.step_fails
                     + u_elevator.u_car_controller.u_elevator_assertions.hold_fails;
        $display("Check summary: %0d errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, assert_fails);
        if (errors == 0 && timeouts == 0 && assert_fails == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* elevator_vectors.txt */
# Commands: req <floor> <dir 1=up 0=down> | emg on | emg off
#           stops <expected door-open floors in order> | idle <floor>
idle 0          # Green at floor 0 after reset

# Single up call, car climbs one floor at a time
req 5 1
stops 5
idle 5

# Call at the current floor, door opens in place
req 5 0
stops 5
idle 5

# Return to the ground floor
req 0 0
stops 0
idle 0

# Three calls from idle, nearest call above is served first
req 2 1
req 6 1
req 4 0
stops 2 4 6
idle 6

# Emergency while travelling down, target still reached
req 1 0
emg on
emg off
stops 1
idle 1

/* filelist.f */
elevator_pkg.sv
call_register.sv
target_select.sv
car_controller.sv
floor_display.sv
elevator.sv
elevator_assertions.sv
tb_elevator.sv

/* Makefile */
# Verilator build and run of the elevator testbench
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the elevator testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_elevator \
		-f filelist.f --Mdir obj_dir -o sim_elevator
	@out=$$(./obj_dir/sim_elevator +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
